//--- verif/ex_flu_vectors.txt
// test kind op a b imm pc ptaken ptarget | exp_result flags(b1 taken, b0 mispredict) target exc
// kind 0 alu 1 branch 2 csr 3 mult 4 flush; csr imm = cycles to commit (0 waits for flush)
1 0 0 5 3 0 0 0 0 8 0 0 0
2 0 1 3 5 0 0 0 0 fffffffe 0 0 0
3 0 2 f0f0ff00 0ff0f0f0 0 0 0 0 00f0f000 0 0 0
4 0 3 f0f0ff00 0ff0f0f0 0 0 0 0 fff0fff0 0 0 0
5 0 4 f0f0ff00 0ff0f0f0 0 0 0 0 ff000ff0 0 0 0
6 0 5 1 1f 0 0 0 0 80000000 0 0 0
7 0 5 12345678 24 0 0 0 0 23456780 0 0 0
8 0 6 80000000 4 0 0 0 0 08000000 0 0 0
9 0 7 80000000 4 0 0 0 0 f8000000 0 0 0
a 0 7 7ffffff0 4 0 0 0 0 07ffffff 0 0 0
b 0 8 ffffffff 1 0 0 0 0 1 0 0 0
c 0 9 ffffffff 1 0 0 0 0 0 0 0 0
d 0 8 5 5 0 0 0 0 0 0 0 0
e 0 9 1 ffffffff 0 0 0 0 1 0 0 0
f 1 a 7 7 20 1000 1 1020 1004 2 1020 0
10 1 b 7 7 20 1000 1 1020 1004 1 1004 0
11 1 c fffffff0 10 fffffff8 2000 0 0 2004 3 1ff8 0
12 1 d fffffff0 10 40 2000 0 0 2004 0 2004 0
13 1 e fffffff0 10 40 3000 1 3040 3004 1 3004 0
14 1 f fffffff0 10 40 3000 1 3080 3004 3 3040 0
15 1 10 0 0 100 4000 1 4100 4004 2 4100 0
16 1 11 5001 0 0 4000 1 5000 4004 2 5000 0
17 1 11 5000 0 7 4010 1 5006 4014 2 5006 1
18 1 10 0 0 6 6000 0 0 6004 3 6006 1
19 1 a 1 2 2 7000 0 0 7004 0 7004 0
1a 3 12 7 6 0 0 0 0 2a 0 0 0
1b 3 12 ffffffff ffffffff 0 0 0 0 1 0 0 0
1c 3 13 ffffffff ffffffff 0 0 0 0 0 0 0 0
1d 3 14 ffffffff ffffffff 0 0 0 0 fffffffe 0 0 0
1e 3 13 80000000 2 0 0 0 0 ffffffff 0 0 0
1f 3 14 80000000 2 0 0 0 0 1 0 0 0
20 3 12 12345678 10 0 0 0 0 23456780 0 0 0
21 0 0 ffffffff 1 0 0 0 0 0 0 0 0
22 2 15 deadbeef 305 3 0 0 0 deadbeef 0 305 0
23 2 15 cafe 12342 1 0 0 0 cafe 0 342 0
24 2 15 11112222 b00 0 0 0 0 11112222 0 b00 0
25 0 3 1 2 0 0 0 0 3 0 0 0
26 3 12 3 3 0 0 0 0 9 0 0 0
27 4 0 0 0 0 0 0 0 0 0 0 0
28 2 15 a5a5a5a5 fff 2 0 0 0 a5a5a5a5 0 fff 0
29 3 12 5 5 0 0 0 0 19 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0

//--- ex_flu.f
common/flu_pkg.sv
alu/alu_branch.sv
mult/mult_pipe.sv
rtl/flu_writeback.sv
rtl/ex_flu.sv
verif/tb_ex_flu.sv

//--- Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_ex_flu
FILELIST  ?= ex_flu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VECTORS   ?= verif/ex_flu_vectors.txt
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(VECTORS)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "sim passed" $(LOG) || { echo "No result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/tb_ex_flu.sv
// Testbench for the fixed-latency execute stage, driven and checked from a vector file
`timescale 1ns/100ps
`default_nettype none

module tb_ex_flu;

    localparam int          NF            = 13;
    localparam int          MAX_VEC       = 64;
    localparam int          READY_TIMEOUT = 50;
    localparam logic [31:0] SEED          = 32'h6e89_b94a;
    // Vector kinds
    localparam logic [31:0] K_ALU    = 32'd0;
    localparam logic [31:0] K_BRANCH = 32'd1;
    localparam logic [31:0] K_CSR    = 32'd2;
    localparam logic [31:0] K_MULT   = 32'd3;
    localparam logic [31:0] K_FLUSH  = 32'd4;

    logic                                clk_i;
    logic                                rst_ni;
    logic                                flush_i;
    flu_pkg::fu_data_t                   fu_data_i;
    logic [flu_pkg::XLEN-1:0]            pc_i;
    logic                                alu_valid_i;
    logic                                branch_valid_i;
    flu_pkg::branch_predict_t            branch_predict_i;
    logic                                csr_valid_i;
    logic                                csr_commit_i;
    logic                                mult_valid_i;
    logic [flu_pkg::XLEN-1:0]            flu_result_o;
    logic [flu_pkg::TRANS_ID_BITS-1:0]   flu_trans_id_o;
    logic                                flu_valid_o;
    logic                                flu_ready_o;
    flu_pkg::exception_t                 flu_exception_o;
    flu_pkg::bp_resolve_t                resolved_branch_o;
    logic                                resolve_branch_o;
    logic [flu_pkg::CSR_ADDR_BITS-1:0]   csr_addr_o;

    // One vector is NF consecutive words
    logic [31:0] vec_mem [0:NF*MAX_VEC-1];
    logic [31:0] lfsr;
    logic [31:0] prev_kind;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    bit          timed_out;
    // Multiply result still due on the port
    bit          mult_pending;
    logic [31:0] mult_exp;
    logic [2:0]  mult_id;

    ex_flu i_ex_flu (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic string kind_name(input logic [31:0] kind);
        case (kind)
            K_ALU:    return "alu";
            K_BRANCH: return "branch";
            K_CSR:    return "csr";
            K_MULT:   return "mult";
            default:  return "flush";
        endcase
    endfunction

    // Two bits, one step each
    task automatic draw_gap(output logic [1:0] gap);
        lfsr   = lfsr_step(lfsr);
        gap[0] = lfsr[0];
        lfsr   = lfsr_step(lfsr);
        gap[1] = lfsr[0];
    endtask

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic clear_inputs();
        flush_i        = 1'b0;
        alu_valid_i    = 1'b0;
        branch_valid_i = 1'b0;
        csr_valid_i    = 1'b0;
        csr_commit_i   = 1'b0;
        mult_valid_i   = 1'b0;
    endtask

    // Drive 1 ns after the rising edge
    task automatic start_cycle();
        @(posedge clk_i);
        #1;
        clear_inputs();
    endtask

    // Sample mid-cycle, then check a multiply issued last cycle
    task automatic settle_and_check_mult();
        #3;
        if (mult_pending) begin
            check_val(32'(flu_valid_o), 32'd1, "mult valid");
            check_val(flu_result_o, mult_exp, "mult result");
            check_val(32'(flu_trans_id_o), 32'(mult_id), "mult trans_id");
            mult_pending = 1'b0;
        end
    endtask

    task automatic idle_cycle();
        bit had_pending;
        had_pending = mult_pending;
        start_cycle();
        settle_and_check_mult();
        if (!had_pending) begin
            check_val(32'(flu_valid_o), 32'd0, "valid while idle");
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (flu_ready_o !== 1'b1 && n < READY_TIMEOUT) begin
            idle_cycle();
            n++;
        end
        if (flu_ready_o !== 1'b1) begin
            $display("Timed out after %0d cycles waiting for flu_ready_o", n);
            timed_out = 1'b1;
        end
    endtask

    task automatic drive_payload(input int base);
        fu_data_i.operator      = flu_pkg::fu_op_e'(vec_mem[base+2][4:0]);
        fu_data_i.operand_a     = vec_mem[base+3];
        fu_data_i.operand_b     = vec_mem[base+4];
        fu_data_i.imm           = vec_mem[base+5];
        // Entry ID from the test number
        fu_data_i.trans_id      = vec_mem[base][2:0];
        pc_i                    = vec_mem[base+6];
        branch_predict_i.taken  = vec_mem[base+7][0];
        branch_predict_i.target = vec_mem[base+8];
    endtask

    // Same-cycle write-back of a single-cycle unit
    task automatic check_port(input int base);
        check_val(32'(flu_valid_o), 32'd1, "flu_valid_o");
        check_val(flu_result_o, vec_mem[base+9], "flu_result_o");
        check_val(32'(flu_trans_id_o), 32'(vec_mem[base][2:0]), "flu_trans_id_o");
        check_val(32'(flu_exception_o.valid), 32'(vec_mem[base+12][0]), "exception valid");
    endtask

    // ----------------------------------------
    // One vector
    // ----------------------------------------
    task automatic run_vector(input int base);
        logic [31:0] kind;
        logic [31:0] flags;
        logic [31:0] exp_tgt;
        logic [1:0]  gap;
        kind    = vec_mem[base+1];
        flags   = vec_mem[base+10];
        exp_tgt = vec_mem[base+11];
        draw_gap(gap);
        // Multiplies and the flush after them go back to back
        if ((kind == K_MULT || kind == K_FLUSH) && prev_kind == K_MULT) begin
            gap = 2'd0;
        end else if (mult_pending && gap == 2'd0) begin
            // That cycle belongs to the multiply result
            gap = 2'd1;
        end
        repeat (gap) idle_cycle();
        case (kind)
            K_ALU: begin
                start_cycle();
                drive_payload(base);
                alu_valid_i = 1'b1;
                settle_and_check_mult();
                check_port(base);
                check_val(32'(resolve_branch_o), 32'd0, "resolve_branch_o");
                check_val(32'(resolved_branch_o.valid), 32'd0, "resolved valid");
            end
            K_BRANCH: begin
                start_cycle();
                drive_payload(base);
                branch_valid_i = 1'b1;
                settle_and_check_mult();
                check_port(base);
                check_val(32'(resolve_branch_o), 32'd1, "resolve_branch_o");
                check_val(32'(resolved_branch_o.valid), 32'd1, "resolved valid");
                check_val(resolved_branch_o.pc, pc_i, "resolved pc");
                check_val(resolved_branch_o.target_address, exp_tgt, "target");
                check_val(32'(resolved_branch_o.is_taken), 32'(flags[1]), "is_taken");
                check_val(32'(resolved_branch_o.is_mispredict), 32'(flags[0]), "mispredict");
                if (vec_mem[base+12][0]) begin
                    check_val(flu_exception_o.tval, exp_tgt, "exception tval");
                    check_val(32'(flu_exception_o.cause), 32'd0, "exception cause");
                end
            end
            K_CSR: begin
                wait_ready();
                if (!timed_out) begin
                    start_cycle();
                    drive_payload(base);
                    csr_valid_i = 1'b1;
                    settle_and_check_mult();
                    check_port(base);
                    // imm holds the cycles until commit, zero leaves it pending
                    if (vec_mem[base+5] != 32'd0) begin
                        repeat (vec_mem[base+5]) begin
                            idle_cycle();
                            check_val(32'(flu_ready_o), 32'd0, "ready while full");
                            check_val(32'(csr_addr_o), exp_tgt, "csr_addr_o");
                        end
                        start_cycle();
                        csr_commit_i = 1'b1;
                        settle_and_check_mult();
                        check_val(32'(flu_ready_o), 32'd0, "ready in commit cycle");
                        idle_cycle();
                        check_val(32'(flu_ready_o), 32'd1, "ready after commit");
                    end
                end
            end
            K_MULT: begin
                start_cycle();
                drive_payload(base);
                mult_valid_i = 1'b1;
                settle_and_check_mult();
                mult_pending = 1'b1;
                mult_exp     = vec_mem[base+9];
                mult_id      = vec_mem[base][2:0];
            end
            default: begin
                start_cycle();
                flush_i = 1'b1;
                #3;
                // Squashed multiply never reaches the port
                check_val(32'(flu_valid_o), 32'd0, "valid in flush cycle");
                mult_pending = 1'b0;
                idle_cycle();
                check_val(32'(flu_ready_o), 32'd1, "ready after flush");
            end
        endcase
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        rst_ni           = 1'b0;
        clear_inputs();
        fu_data_i        = '0;
        pc_i             = '0;
        branch_predict_i = '0;
        lfsr             = SEED;
        prev_kind        = K_FLUSH;
        errors           = 0;
        test_errors      = 0;
        tests_run        = 0;
        tests_failed     = 0;
        timed_out        = 1'b0;
        mult_pending     = 1'b0;
        mult_exp         = '0;
        mult_id          = '0;
        $readmemh("verif/ex_flu_vectors.txt", vec_mem);
        repeat (16) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        for (int i = 0; i < MAX_VEC; i++) begin
            // Test number zero ends the list
            if (vec_mem[i*NF] == 32'd0) begin
                break;
            end
            test_errors = 0;
            run_vector(i * NF);
            tests_run++;
            if (test_errors != 0) begin
                tests_failed++;
            end
            errors += test_errors;
            $display("test %0d %s: %s", vec_mem[i*NF], kind_name(vec_mem[i*NF+1]),
                     (test_errors == 0) ? "ok" : "FAILED");
            prev_kind = vec_mem[i*NF+1];
            if (timed_out) begin
                break;
            end
        end
        // Drain a trailing multiply
        test_errors = 0;
        if (!timed_out) begin
            idle_cycle();
            idle_cycle();
        end
        errors += test_errors;
        $display("tests run %0d, tests failed %0d, checks failed %0d, timeout %0d",
                 tests_run, tests_failed, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/ex_flu.sv
// Fixed-latency execute stage with ALU, branch unit, CSR buffer and multiplier on one port
`timescale 1ns/100ps
`default_nettype none

module ex_flu (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                flush_i,
    // Issue port
    input  flu_pkg::fu_data_t                   fu_data_i,
    input  logic [flu_pkg::XLEN-1:0]            pc_i,
    input  logic                                alu_valid_i,
    input  logic                                branch_valid_i,
    input  flu_pkg::branch_predict_t            branch_predict_i,
    input  logic                                csr_valid_i,
    input  logic                                csr_commit_i,
    input  logic                                mult_valid_i,
    // Write-back port
    output logic [flu_pkg::XLEN-1:0]            flu_result_o,
    output logic [flu_pkg::TRANS_ID_BITS-1:0]   flu_trans_id_o,
    output logic                                flu_valid_o,
    output logic                                flu_ready_o,
    output flu_pkg::exception_t                 flu_exception_o,
    // Branch resolution
    output flu_pkg::bp_resolve_t                resolved_branch_o,
    output logic                                resolve_branch_o,
    // Buffered CSR address
    output logic [flu_pkg::CSR_ADDR_BITS-1:0]   csr_addr_o
);

    // ALU and branch results
    logic [flu_pkg::XLEN-1:0]          alu_result;
    logic [flu_pkg::XLEN-1:0]          branch_result;
    flu_pkg::exception_t               branch_exception;
    // Multiplier output stage
    logic                              mult_valid;
    logic [flu_pkg::XLEN-1:0]          mult_result;
    logic [flu_pkg::TRANS_ID_BITS-1:0] mult_trans_id;

    // --------------------------------------
    // Single-cycle units
    // --------------------------------------
    alu_branch i_alu_branch (
        .fu_data_i          ( fu_data_i         ),
        .alu_valid_i        ( alu_valid_i       ),
        .branch_valid_i     ( branch_valid_i    ),
        .pc_i               ( pc_i              ),
        .branch_predict_i   ( branch_predict_i  ),
        .alu_result_o       ( alu_result        ),
        .branch_result_o    ( branch_result     ),
        .resolved_branch_o  ( resolved_branch_o ),
        .resolve_branch_o   ( resolve_branch_o  ),
        .branch_exception_o ( branch_exception  )
    );

    // One cycle of latency
    mult_pipe i_mult_pipe (
        .clk_i           ( clk_i         ),
        .rst_ni          ( rst_ni        ),
        .flush_i         ( flush_i       ),
        .mult_valid_i    ( mult_valid_i  ),
        .fu_data_i       ( fu_data_i     ),
        .mult_valid_o    ( mult_valid    ),
        .mult_result_o   ( mult_result   ),
        .mult_trans_id_o ( mult_trans_id )
    );

    // --------------------------------------
    // Write-back and CSR buffer
    // --------------------------------------
    flu_writeback i_flu_writeback (
        .clk_i              ( clk_i            ),
        .rst_ni             ( rst_ni           ),
        .flush_i            ( flush_i          ),
        .fu_data_i          ( fu_data_i        ),
        .alu_valid_i        ( alu_valid_i      ),
        .branch_valid_i     ( branch_valid_i   ),
        .csr_valid_i        ( csr_valid_i      ),
        .csr_commit_i       ( csr_commit_i     ),
        .alu_result_i       ( alu_result       ),
        .branch_result_i    ( branch_result    ),
        .branch_exception_i ( branch_exception ),
        .mult_valid_i       ( mult_valid       ),
        .mult_result_i      ( mult_result      ),
        .mult_trans_id_i    ( mult_trans_id    ),
        .flu_result_o       ( flu_result_o     ),
        .flu_trans_id_o     ( flu_trans_id_o   ),
        .flu_valid_o        ( flu_valid_o      ),
        .flu_ready_o        ( flu_ready_o      ),
        .flu_exception_o    ( flu_exception_o  ),
        .csr_addr_o         ( csr_addr_o       )
    );

endmodule

`default_nettype wire

//--- rtl/flu_writeback.sv
// CSR address buffer and prioritized result merge onto the shared write-back port
`timescale 1ns/100ps
`default_nettype none

module flu_writeback (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                flush_i,
    input  flu_pkg::fu_data_t                   fu_data_i,
    input  logic                                alu_valid_i,
    input  logic                                branch_valid_i,
    input  logic                                csr_valid_i,
    input  logic                                csr_commit_i,
    // Single-cycle results
    input  logic [flu_pkg::XLEN-1:0]            alu_result_i,
    input  logic [flu_pkg::XLEN-1:0]            branch_result_i,
    input  flu_pkg::exception_t                 branch_exception_i,
    // Multiplier stage
    input  logic                                mult_valid_i,
    input  logic [flu_pkg::XLEN-1:0]            mult_result_i,
    input  logic [flu_pkg::TRANS_ID_BITS-1:0]   mult_trans_id_i,
    // Write-back port
    output logic [flu_pkg::XLEN-1:0]            flu_result_o,
    output logic [flu_pkg::TRANS_ID_BITS-1:0]   flu_trans_id_o,
    output logic                                flu_valid_o,
    output logic                                flu_ready_o,
    output flu_pkg::exception_t                 flu_exception_o,
    output logic [flu_pkg::CSR_ADDR_BITS-1:0]   csr_addr_o
);

    logic                              csr_full_q;
    logic [flu_pkg::CSR_ADDR_BITS-1:0] csr_addr_q;

    // --------------------------------------
    // CSR buffer
    // --------------------------------------
    // One entry, value is re-read at commit
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            csr_full_q <= 1'b0;
        end else if (flush_i) begin
            csr_full_q <= 1'b0;
        end else if (csr_valid_i) begin
            csr_full_q <= 1'b1;
        end else if (csr_commit_i) begin
            // Freed by the commit pulse
            csr_full_q <= 1'b0;
        end
    end

    // Address sits in operand_b
    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            csr_addr_q <= fu_data_i.operand_b[flu_pkg::CSR_ADDR_BITS-1:0];
        end
    end

    assign csr_addr_o  = csr_addr_q;
    // Full buffer stalls the whole port
    assign flu_ready_o = ~csr_full_q;

    // --------------------------------------
    // Result merge
    // --------------------------------------
    assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid_i;

    always_comb begin
        // Link value by default
        flu_result_o   = branch_result_i;
        flu_trans_id_o = fu_data_i.trans_id;
        if (alu_valid_i) begin
            flu_result_o = alu_result_i;
        end else if (csr_valid_i) begin
            // CSR writes back operand_a
            flu_result_o = fu_data_i.operand_a;
        end else if (mult_valid_i) begin
            // Late result keeps its own ID
            flu_result_o   = mult_result_i;
            flu_trans_id_o = mult_trans_id_i;
        end
    end

    // Only branches raise exceptions here
    assign flu_exception_o = branch_exception_i;

    a_csr_when_ready: assert property (
        @(posedge clk_i) disable iff (!rst_ni) csr_valid_i |-> !csr_full_q
    ) else $error("CSR issued while the buffer is full");

    a_mult_slot_free: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        mult_valid_i |-> !(alu_valid_i || branch_valid_i || csr_valid_i)
    ) else $error("Issue collided with a multiplier result");

endmodule

`default_nettype wire

//--- mult/mult_pipe.sv
// Single-stage pipelined 32-bit multiplier with transaction ID and flush
`timescale 1ns/100ps
`default_nettype none

module mult_pipe (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              flush_i,
    input  logic                              mult_valid_i,
    input  flu_pkg::fu_data_t                 fu_data_i,
    output logic                              mult_valid_o,
    output logic [flu_pkg::XLEN-1:0]          mult_result_o,
    output logic [flu_pkg::TRANS_ID_BITS-1:0] mult_trans_id_o
);

    flu_pkg::fu_data_t                 mult_data;
    // Operands widened to the full product width
    logic [2*flu_pkg::XLEN-1:0]        op_a_s;
    logic [2*flu_pkg::XLEN-1:0]        op_b_s;
    logic [2*flu_pkg::XLEN-1:0]        op_a_u;
    logic [2*flu_pkg::XLEN-1:0]        op_b_u;
    logic [2*flu_pkg::XLEN-1:0]        prod_s;
    logic [2*flu_pkg::XLEN-1:0]        prod_u;
    logic [flu_pkg::XLEN-1:0]          result_d;
    // Output stage
    logic                              valid_q;
    logic [flu_pkg::XLEN-1:0]          result_q;
    logic [flu_pkg::TRANS_ID_BITS-1:0] trans_id_q;

    // Input silencing
    assign mult_data = mult_valid_i ? fu_data_i : '0;

    assign op_a_s = {{flu_pkg::XLEN{mult_data.operand_a[flu_pkg::XLEN-1]}}, mult_data.operand_a};
    assign op_b_s = {{flu_pkg::XLEN{mult_data.operand_b[flu_pkg::XLEN-1]}}, mult_data.operand_b};
    assign op_a_u = {{flu_pkg::XLEN{1'b0}}, mult_data.operand_a};
    assign op_b_u = {{flu_pkg::XLEN{1'b0}}, mult_data.operand_b};

    // low half of a sign-extended product is the signed product
    assign prod_s = op_a_s * op_b_s;
    assign prod_u = op_a_u * op_b_u;

    always_comb begin
        case (mult_data.operator)
            flu_pkg::MUL:   result_d = prod_u[flu_pkg::XLEN-1:0];
            flu_pkg::MULH:  result_d = prod_s[2*flu_pkg::XLEN-1:flu_pkg::XLEN];
            flu_pkg::MULHU: result_d = prod_u[2*flu_pkg::XLEN-1:flu_pkg::XLEN];
            default:        result_d = '0;
        endcase
    end

    // --------------------------------------
    // Pipeline stage
    // --------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            // Drop an op issued in the flush cycle
            valid_q <= mult_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        result_q   <= result_d;
        trans_id_q <= mult_data.trans_id;
    end

    // Also squash the op issued one cycle before the flush
    assign mult_valid_o    = valid_q & ~flush_i;
    assign mult_result_o   = result_q;
    assign mult_trans_id_o = trans_id_q;

    a_flush_kills_result: assert property (
        @(posedge clk_i) disable iff (!rst_ni) flush_i |=> !mult_valid_o
    ) else $error("Multiplier result after flush");

endmodule

`default_nettype wire

//--- alu/alu_branch.sv
// Combinational integer ALU and branch resolution with misalignment check
`timescale 1ns/100ps
`default_nettype none

module alu_branch (
    input  flu_pkg::fu_data_t        fu_data_i,
    input  logic                     alu_valid_i,
    input  logic                     branch_valid_i,
    input  logic [flu_pkg::XLEN-1:0] pc_i,
    input  flu_pkg::branch_predict_t branch_predict_i,
    output logic [flu_pkg::XLEN-1:0] alu_result_o,
    output logic [flu_pkg::XLEN-1:0] branch_result_o,
    output flu_pkg::bp_resolve_t     resolved_branch_o,
    output logic                     resolve_branch_o,
    output flu_pkg::exception_t      branch_exception_o
);

    // Silenced issue payload
    flu_pkg::fu_data_t        alu_data;
    logic [flu_pkg::XLEN-1:0] op_a;
    logic [flu_pkg::XLEN-1:0] op_b;
    logic [4:0]               shamt;
    // Shared compare terms
    logic                     is_eq;
    logic                     is_lts;
    logic                     is_ltu;
    logic                     cmp_true;
    // Branch datapath
    logic                     is_jalr;
    logic [flu_pkg::XLEN-1:0] jump_base;
    logic [flu_pkg::XLEN-1:0] target_sum;
    logic [flu_pkg::XLEN-1:0] jump_target;
    logic [flu_pkg::XLEN-1:0] next_pc;
    logic                     mispredict;

    // Keep the datapath quiet while no ALU or branch op is issued
    assign alu_data = (alu_valid_i | branch_valid_i) ? fu_data_i : '0;
    assign op_a     = alu_data.operand_a;
    assign op_b     = alu_data.operand_b;
    assign shamt    = op_b[4:0];

    assign is_eq  = (op_a == op_b);
    assign is_lts = ($signed(op_a) < $signed(op_b));
    assign is_ltu = (op_a < op_b);

    // --------------------------------------
    // ALU
    // --------------------------------------
    always_comb begin
        alu_result_o = '0;
        case (alu_data.operator)
            flu_pkg::ADD:  alu_result_o = op_a + op_b;
            flu_pkg::SUB:  alu_result_o = op_a - op_b;
            flu_pkg::AND:  alu_result_o = op_a & op_b;
            flu_pkg::OR:   alu_result_o = op_a | op_b;
            flu_pkg::XOR:  alu_result_o = op_a ^ op_b;
            flu_pkg::SLL:  alu_result_o = op_a << shamt;
            flu_pkg::SRL:  alu_result_o = op_a >> shamt;
            flu_pkg::SRA:  alu_result_o = $unsigned($signed(op_a) >>> shamt);
            // Set-less-than gives a single bit
            flu_pkg::SLT:  alu_result_o = {{(flu_pkg::XLEN-1){1'b0}}, is_lts};
            flu_pkg::SLTU: alu_result_o = {{(flu_pkg::XLEN-1){1'b0}}, is_ltu};
            default:       alu_result_o = '0;
        endcase
    end

    // --------------------------------------
    // Branch compare
    // --------------------------------------
    always_comb begin
        cmp_true = 1'b0;
        case (alu_data.operator)
            flu_pkg::EQ:   cmp_true = is_eq;
            flu_pkg::NE:   cmp_true = ~is_eq;
            flu_pkg::LTS:  cmp_true = is_lts;
            flu_pkg::GES:  cmp_true = ~is_lts;
            flu_pkg::LTU:  cmp_true = is_ltu;
            flu_pkg::GEU:  cmp_true = ~is_ltu;
            // Jumps are always taken
            flu_pkg::JAL:  cmp_true = 1'b1;
            flu_pkg::JALR: cmp_true = 1'b1;
            default:       cmp_true = 1'b0;
        endcase
    end

    // Target from pc, or from rs1 for JALR
    assign is_jalr     = (alu_data.operator == flu_pkg::JALR);
    assign jump_base   = is_jalr ? op_a : pc_i;
    assign target_sum  = jump_base + alu_data.imm;
    // JALR clears bit 0
    assign jump_target = {target_sum[flu_pkg::XLEN-1:1], target_sum[0] & ~is_jalr};

    // Link and fall-through address
    assign next_pc         = pc_i + flu_pkg::INSTR_BYTES;
    assign branch_result_o = next_pc;

    // Wrong direction, or taken to the wrong place
    assign mispredict = (cmp_true != branch_predict_i.taken) ||
                        (cmp_true && (jump_target != branch_predict_i.target));

    // --------------------------------------
    // Resolution to the frontend
    // --------------------------------------
    assign resolve_branch_o                 = branch_valid_i;
    assign resolved_branch_o.valid          = branch_valid_i;
    assign resolved_branch_o.pc             = pc_i;
    assign resolved_branch_o.target_address = cmp_true ? jump_target : next_pc;
    assign resolved_branch_o.is_taken       = branch_valid_i & cmp_true;
    assign resolved_branch_o.is_mispredict  = branch_valid_i & mispredict;

    // Taken target must be word aligned
    assign branch_exception_o.valid = branch_valid_i & cmp_true & jump_target[1];
    assign branch_exception_o.cause = flu_pkg::INSTR_ADDR_MISALIGNED;
    assign branch_exception_o.tval  = jump_target;

    // Issue sends at most one op to this datapath per cycle
    always_comb begin
        assert (!(alu_valid_i && branch_valid_i))
            else $error("ALU and branch issued in the same cycle");
    end

endmodule

`default_nettype wire

//--- common/flu_pkg.sv
// Shared widths, operator encoding and payload types of the fixed-latency execute units
`default_nettype none

package flu_pkg;

    // --------------------------------------
    // Widths
    // --------------------------------------
    // Data and address width
    localparam int unsigned XLEN          = 32;
    // Scoreboard entry ID
    localparam int unsigned TRANS_ID_BITS = 3;
    localparam int unsigned CSR_ADDR_BITS = 12;
    // All instructions are uncompressed
    localparam int unsigned INSTR_BYTES   = 4;

    // Exception causes
    localparam logic [3:0] INSTR_ADDR_MISALIGNED = 4'd0;

    // --------------------------------------
    // Operators
    // --------------------------------------
    typedef enum logic [4:0] {
        // ALU
        ADD     = 5'h00,
        SUB     = 5'h01,
        AND     = 5'h02,
        OR      = 5'h03,
        XOR     = 5'h04,
        SLL     = 5'h05,
        SRL     = 5'h06,
        SRA     = 5'h07,
        SLT     = 5'h08,
        SLTU    = 5'h09,
        // Branch compares
        EQ      = 5'h0a,
        NE      = 5'h0b,
        LTS     = 5'h0c,
        GES     = 5'h0d,
        LTU     = 5'h0e,
        GEU     = 5'h0f,
        // Jumps
        JAL     = 5'h10,
        JALR    = 5'h11,
        // Multiplier
        MUL     = 5'h12,
        MULH    = 5'h13,
        MULHU   = 5'h14,
        // CSR buffer
        CSR_ACC = 5'h15
    } fu_op_e;

    // --------------------------------------
    // Payloads
    // --------------------------------------
    // Issue payload shared by all units
    typedef struct packed {
        fu_op_e                   operator;
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          operand_b;
        logic [XLEN-1:0]          imm;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    // Prediction made at fetch
    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } branch_predict_t;

    // Resolution sent back to the frontend
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target_address;
        logic            is_taken;
        logic            is_mispredict;
    } bp_resolve_t;

    typedef struct packed {
        logic            valid;
        logic [3:0]      cause;
        logic [XLEN-1:0] tval;
    } exception_t;

endpackage

`default_nettype wire
